// ==== common/frontend_cfg.svh ====
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FE_DATA_W          256
`define FE_KEEP_W          32
`define FE_LANES           8
`define FE_LANE_W          32
`define FE_BITMAP_W        16     // two code bits per lane

// compressed frame layout
`define FE_HDR_BEATS       4      // header beats sent as they are
`define FE_COMP_GROUPS     44

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// classification
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FE_IP_PROTO_TCP    6
`define FE_COMP_FRAME_LEN  1514
`define FE_ETH_HDR_LEN     14     // added to the ip total length

`endif

// ==== common/frontend_pkg.sv ====
`default_nettype none

`include "frontend_cfg.svh"

package frontend_pkg;

    // one stream transfer
    typedef struct packed {
        logic [`FE_DATA_W-1:0] data;
        logic [`FE_KEEP_W-1:0] keep;
        logic                  last;
    } axis_beat_t;

    typedef enum logic [1:0] {
        LC_ZERO = 2'd0,
        LC_BYTE = 2'd1,
        LC_HALF = 2'd2,
        LC_FULL = 2'd3
    } lane_code_e;

    // header fields of the first beat, byte 0 sits in the lsbs
    typedef struct packed {
        logic [63:0] pad_top;
        logic [7:0]  ip_proto;     // 191:184
        logic [39:0] pad_ip;
        logic [7:0]  ip_len_lsb;
        logic [7:0]  ip_len_msb;   // network order, msb byte first
        logic [7:0]  tos;          // 127:120
        logic [7:0]  pad_ver;
        logic [15:0] eth_type;     // 111:96
        logic [95:0] pad_mac;
    } hdr_view_t;

    typedef union packed {
        logic [`FE_DATA_W-1:0] raw;
        hdr_view_t             hdr;
    } first_beat_u;

    // one group cut out of the payload stream
    typedef struct packed {
        logic [`FE_BITMAP_W-1:0] bitmap;
        logic [`FE_DATA_W-1:0]   lanes;    // packed lane values from bit 0
        logic                    last;
    } comp_group_t;

    function automatic logic [5:0] lane_bits(lane_code_e code);
        case (code)
            LC_ZERO: return 6'd0;
            LC_BYTE: return 6'd8;
            LC_HALF: return 6'd16;
            default: return 6'd32;   // full word
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/pkt_classifier.sv ====
`default_nettype none

`include "frontend_cfg.svh"

module pkt_classifier
    import frontend_pkg::*;
(
    input  wire logic       aclk,
    input  wire logic       aresetn,
    input  wire axis_beat_t s_beat,
    input  wire logic       s_valid,
    output logic            s_ready,
    output axis_beat_t      pass_beat,
    output logic            pass_valid,
    input  wire logic       pass_ready,
    output axis_beat_t      pay_beat,
    output logic            pay_valid,
    input  wire logic       pay_ready,
    input  wire logic       comp_done,
    output logic            need_decomp
);

    localparam int HCNT_W = $clog2(`FE_HDR_BEATS + 1);

    typedef enum logic [1:0] {
        PH_FIRST,
        PH_PASS,
        PH_PAY,
        PH_DRAIN
    } phase_e;

    phase_e            phase;
    logic [HCNT_W-1:0] hdr_cnt;      // header beats already sent
    first_beat_u       fb;
    logic [15:0]       ip_len;
    logic              is_comp;
    logic              xfer;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // first beat decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign fb.raw  = s_beat.data;
    assign ip_len  = {fb.hdr.ip_len_msb, fb.hdr.ip_len_lsb};
    assign is_comp = (fb.hdr.ip_proto == 8'(`FE_IP_PROTO_TCP)) &&
                     (fb.hdr.tos != 8'd0) &&
                     (ip_len + 16'(`FE_ETH_HDR_LEN) == 16'(`FE_COMP_FRAME_LEN));

    // steering follows the phase in the same cycle
    always_comb begin
        pass_valid = 1'b0;
        pay_valid  = 1'b0;
        s_ready    = 1'b0;
        case (phase)
            PH_FIRST, PH_PASS: begin
                pass_valid = s_valid;
                s_ready    = pass_ready;
            end
            PH_PAY: begin
                pay_valid = s_valid;
                s_ready   = pay_ready;
            end
            default: ;   // window still draining, hold the next packet
        endcase
    end

    assign pass_beat = s_beat;
    assign pay_beat  = s_beat;
    assign xfer      = s_valid && s_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            phase       <= PH_FIRST;
            hdr_cnt     <= '0;
            need_decomp <= 1'b0;
        end else begin
            case (phase)
                PH_FIRST: begin
                    if (xfer) begin
                        need_decomp <= is_comp;
                        hdr_cnt     <= HCNT_W'(1);
                        if (s_beat.last) begin
                            phase <= PH_FIRST;   // single beat packet
                        end else if (is_comp && `FE_HDR_BEATS == 1) begin
                            phase <= PH_PAY;
                        end else begin
                            phase <= PH_PASS;
                        end
                    end
                end
                PH_PASS: begin
                    if (xfer) begin
                        hdr_cnt <= hdr_cnt + 1'b1;
                        if (s_beat.last) begin
                            phase <= PH_FIRST;
                        end else if (need_decomp && hdr_cnt == HCNT_W'(`FE_HDR_BEATS - 1)) begin
                            phase <= PH_PAY;
                        end
                    end
                end
                PH_PAY: begin
                    if (xfer && s_beat.last) begin
                        phase <= PH_DRAIN;
                    end
                end
                default: begin
                    if (comp_done) begin
                        phase <= PH_FIRST;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== decomp/bit_window.sv ====
`default_nettype none

`include "frontend_cfg.svh"

module bit_window
    import frontend_pkg::*;
(
    input  wire logic       aclk,
    input  wire logic       aresetn,
    input  wire axis_beat_t pay_beat,
    input  wire logic       pay_valid,
    output logic            pay_ready,
    output comp_group_t     grp,
    output logic            grp_valid,
    input  wire logic       grp_ready,
    output logic            comp_done
);

    localparam int WIN_W   = 2 * `FE_DATA_W;
    localparam int EXT_W   = 3 * `FE_DATA_W;
    localparam int MAX_GRP = `FE_BITMAP_W + `FE_LANES * `FE_LANE_W;   // 272
    localparam int GCNT_W  = $clog2(`FE_COMP_GROUPS + 1);

    logic [WIN_W-1:0]  win;
    logic [9:0]        fill;        // valid bits in win, whole beats
    logic [9:0]        cursor;      // next group start inside win
    logic [GCNT_W-1:0] grp_cnt;
    logic              draining;
    logic              seen_last;

    logic              slot_free;
    logic              take;
    logic              load;
    logic              cut;
    logic              last_grp;
    logic              done_now;
    logic [9:0]        remaining;
    logic [9:0]        ext_fill;
    logic [9:0]        avail;
    logic [9:0]        cursor_c;
    logic [8:0]        step;
    logic [EXT_W-1:0]  ext;
    logic [EXT_W-1:0]  grp_bits;

    assign slot_free = !grp_valid || grp_ready;
    assign remaining = fill - cursor;

    // a full window takes a beat only if a group leaves the low beat this cycle
    always_comb begin
        if (draining) begin
            pay_ready = 1'b1;   // swallow the tail
        end else begin
            pay_ready = !seen_last && (remaining < 10'(MAX_GRP)) &&
                        (fill != 10'(WIN_W) || cursor >= 10'(`FE_DATA_W) || slot_free);
        end
    end

    assign take = pay_valid && pay_ready;
    assign load = take && !draining;

    // new beat lands right above the filled part
    always_comb begin
        case (fill)
            10'd0:             ext = {{WIN_W{1'b0}}, pay_beat.data};
            10'(`FE_DATA_W):   ext = {{`FE_DATA_W{1'b0}}, pay_beat.data, win[`FE_DATA_W-1:0]};
            default:           ext = {pay_beat.data, win};
        endcase
    end

    assign ext_fill = fill + (load ? 10'(`FE_DATA_W) : 10'd0);
    assign avail    = ext_fill - cursor;
    assign grp_bits = ext >> cursor;    // group aligned to bit 0

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // group size from the bitmap
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        step = 9'(`FE_BITMAP_W);
        for (int i = 0; i < `FE_LANES; i++) begin
            step = step + 9'(lane_bits(lane_code_e'(grp_bits[2*i +: 2])));
        end
    end

    assign last_grp = (grp_cnt == GCNT_W'(`FE_COMP_GROUPS - 1));
    assign cut      = !draining && slot_free && (avail >= 10'(`FE_BITMAP_W)) &&
                      (avail >= 10'(step));
    assign cursor_c = cursor + (cut ? 10'(step) : 10'd0);
    assign done_now = draining ? (take && pay_beat.last)
                               : (cut && last_grp && (seen_last || (load && pay_beat.last)));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            fill      <= '0;
            cursor    <= '0;
            grp_cnt   <= '0;
            draining  <= 1'b0;
            seen_last <= 1'b0;
            grp_valid <= 1'b0;
            comp_done <= 1'b0;
        end else begin
            comp_done <= done_now;
            if (cut) begin
                grp_valid <= 1'b1;
            end else if (grp_ready) begin
                grp_valid <= 1'b0;
            end
            if (done_now) begin
                fill      <= '0;
                cursor    <= '0;
                grp_cnt   <= '0;
                draining  <= 1'b0;
                seen_last <= 1'b0;
            end else begin
                if (load && pay_beat.last) begin
                    seen_last <= 1'b1;
                end
                if (cut) begin
                    grp_cnt <= grp_cnt + 1'b1;
                    if (last_grp) begin
                        draining <= 1'b1;
                    end
                end
                // low beat fully consumed
                if (cursor_c >= 10'(`FE_DATA_W)) begin
                    fill   <= ext_fill - 10'(`FE_DATA_W);
                    cursor <= cursor_c - 10'(`FE_DATA_W);
                end else begin
                    fill   <= ext_fill;
                    cursor <= cursor_c;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (cut) begin
            grp.bitmap <= grp_bits[`FE_BITMAP_W-1:0];
            grp.lanes  <= grp_bits[`FE_BITMAP_W +: `FE_DATA_W];
            grp.last   <= last_grp;
        end
        if (cursor_c >= 10'(`FE_DATA_W)) begin
            win <= ext[EXT_W-1:`FE_DATA_W];
        end else begin
            win <= ext[WIN_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== decomp/lane_unpack.sv ====
`default_nettype none

`include "frontend_cfg.svh"

module lane_unpack
    import frontend_pkg::*;
(
    input  wire logic        aclk,
    input  wire logic        aresetn,
    input  wire comp_group_t grp,
    input  wire logic        grp_valid,
    output logic             grp_ready,
    output axis_beat_t       dec_beat,
    output logic             dec_valid,
    input  wire logic        dec_ready
);

    logic [8:0]            off      [`FE_LANES];
    logic [`FE_LANE_W-1:0] lane_raw [`FE_LANES];
    logic [`FE_DATA_W-1:0] expanded;

    // running offsets, lane 0 right after the bitmap
    always_comb begin
        off[0] = '0;
        for (int i = 1; i < `FE_LANES; i++) begin
            off[i] = off[i-1] + 9'(lane_bits(lane_code_e'(grp.bitmap[2*(i-1) +: 2])));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // zero-extend each lane to a full word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        expanded = '0;
        for (int i = 0; i < `FE_LANES; i++) begin
            lane_raw[i] = `FE_LANE_W'(grp.lanes >> off[i]);
            case (lane_code_e'(grp.bitmap[2*i +: 2]))
                LC_ZERO: expanded[i*`FE_LANE_W +: `FE_LANE_W] = '0;
                LC_BYTE: expanded[i*`FE_LANE_W +: `FE_LANE_W] = {24'd0, lane_raw[i][7:0]};
                LC_HALF: expanded[i*`FE_LANE_W +: `FE_LANE_W] = {16'd0, lane_raw[i][15:0]};
                default: expanded[i*`FE_LANE_W +: `FE_LANE_W] = lane_raw[i];
            endcase
        end
    end

    assign grp_ready = !dec_valid || dec_ready;   // one group held at most

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            dec_valid <= 1'b0;
        end else if (grp_valid && grp_ready) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (grp_valid && grp_ready) begin
            dec_beat.data <= expanded;
            dec_beat.keep <= '1;          // always a full beat
            dec_beat.last <= grp.last;
        end
    end

endmodule

`default_nettype wire

// ==== src/stream_out_merge.sv ====
`default_nettype none

module stream_out_merge
    import frontend_pkg::*;
(
    input  wire logic       aclk,
    input  wire logic       aresetn,
    input  wire axis_beat_t pass_beat,
    input  wire logic       pass_valid,
    output logic            pass_ready,
    input  wire axis_beat_t dec_beat,
    input  wire logic       dec_valid,
    output logic            dec_ready,
    output axis_beat_t      m_beat,
    output logic            m_valid,
    input  wire logic       m_ready
);

    logic out_free;

    assign out_free   = !m_valid || m_ready;
    assign dec_ready  = out_free;

    // a decompressed beat still held belongs to the older packet, it goes first
    assign pass_ready = out_free && !dec_valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_valid <= 1'b0;
        end else if (out_free) begin
            m_valid <= dec_valid || pass_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (out_free) begin
            if (dec_valid) begin
                m_beat <= dec_beat;
            end else if (pass_valid) begin
                m_beat <= pass_beat;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/frontend_top.sv ====
`default_nettype none

module frontend_top
    import frontend_pkg::*;
(
    input  wire logic       aclk,
    input  wire logic       aresetn,

    input  wire axis_beat_t s_beat,
    input  wire logic       s_valid,
    output logic            s_ready,

    output axis_beat_t      m_beat,
    output logic            m_valid,
    input  wire logic       m_ready,

    output logic            need_decomp
);

    axis_beat_t  pass_beat;
    logic        pass_valid;
    logic        pass_ready;
    axis_beat_t  pay_beat;
    logic        pay_valid;
    logic        pay_ready;
    logic        comp_done;
    comp_group_t grp;
    logic        grp_valid;
    logic        grp_ready;
    axis_beat_t  dec_beat;
    logic        dec_valid;
    logic        dec_ready;

    pkt_classifier pkt_classifier_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .pass_beat   (pass_beat),
        .pass_valid  (pass_valid),
        .pass_ready  (pass_ready),
        .pay_beat    (pay_beat),
        .pay_valid   (pay_valid),
        .pay_ready   (pay_ready),
        .comp_done   (comp_done),
        .need_decomp (need_decomp)
    );

    bit_window bit_window_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .pay_beat  (pay_beat),
        .pay_valid (pay_valid),
        .pay_ready (pay_ready),
        .grp       (grp),
        .grp_valid (grp_valid),
        .grp_ready (grp_ready),
        .comp_done (comp_done)
    );

    lane_unpack lane_unpack_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .grp       (grp),
        .grp_valid (grp_valid),
        .grp_ready (grp_ready),
        .dec_beat  (dec_beat),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready)
    );

    stream_out_merge stream_out_merge_inst (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .pass_beat  (pass_beat),
        .pass_valid (pass_valid),
        .pass_ready (pass_ready),
        .dec_beat   (dec_beat),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .m_beat     (m_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready)
    );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`default_nettype none

module clk_gen (
    output logic aclk
);

    localparam int HALF_PERIOD = 2;   // 4 unit period

    initial begin
        aclk = 1'b0;
        forever #HALF_PERIOD aclk = ~aclk;
    end

endmodule

`default_nettype wire

// ==== bench/frontend_props.sv ====
`default_nettype none

module frontend_props
    import frontend_pkg::*;
(
    input wire logic       aclk,
    input wire logic       aresetn,
    input wire axis_beat_t m_beat,
    input wire logic       m_valid,
    input wire logic       m_ready
);

    int unsigned assert_fails = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stream rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    hold_while_stalled: assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_ready |=> m_valid && $stable(m_beat))
        else begin
            assert_fails++;
            $error("output beat dropped or changed while m_ready was low");
        end

    // only the closing beat of a packet may be partial
    keep_full_unless_last: assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_beat.last |-> &m_beat.keep)
        else begin
            assert_fails++;
            $error("partial keep on a valid output beat without tlast");
        end

    valid_low_after_reset: assert property (@(posedge aclk)
        !aresetn |=> !m_valid)
        else begin
            assert_fails++;
            $error("m_valid high right after reset");
        end

    no_unknown_out: assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid |-> !$isunknown(m_beat))
        else begin
            assert_fails++;
            $error("unknown bits on the output beat while m_valid");
        end

endmodule

`default_nettype wire

// ==== bench/tb_frontend.sv ====
`default_nettype none

`include "frontend_cfg.svh"

module tb_frontend
    import frontend_pkg::*;
();

    localparam int MAX_GRP_BITS = `FE_BITMAP_W + `FE_LANES * `FE_LANE_W;
    localparam int PAY_MAX      = (`FE_COMP_GROUPS * MAX_GRP_BITS + `FE_DATA_W - 1) / `FE_DATA_W;
    localparam int COMP_MAX     = `FE_HDR_BEATS + PAY_MAX + 2;
    localparam int TOTAL_BEATS  = 6 + 5 + 3 * COMP_MAX + 3 + COMP_MAX + 4;
    localparam int WATCHDOG_CYC = TOTAL_BEATS * 8 + 500;

    logic       aclk;
    logic       aresetn;
    axis_beat_t s_beat;
    logic       s_valid;
    logic       s_ready;
    axis_beat_t m_beat;
    logic       m_valid;
    logic       m_ready;
    logic       need_decomp;

    bit         rand_ready;
    int         val_errs;
    int         other_errs;
    int         out_cnt;
    bit         pkt_start;

    axis_beat_t exp_q[$];      // beats still owed by the DUT
    logic       flag_q[$];     // one class per packet
    axis_beat_t in_q[$];
    axis_beat_t model_q[$];
    logic       model_flag;
    bit         pay_bits[$];   // payload bit stream, lsb first

    clk_gen clk_gen_inst (
        .aclk (aclk)
    );

    frontend_top frontend_top_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .need_decomp (need_decomp)
    );

    bind frontend_top frontend_props frontend_props_inst (
        .aclk    (aclk),
        .aresetn (aresetn),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [`FE_DATA_W-1:0] rand_data();
        logic [`FE_DATA_W-1:0] d;
        for (int i = 0; i < `FE_DATA_W / 32; i++) begin
            d[32*i +: 32] = $urandom;
        end
        return d;
    endfunction

    function automatic logic [`FE_DATA_W-1:0] first_data(input logic [7:0] proto,
                                                        input logic [7:0] tos,
                                                        input logic [15:0] len);
        logic [`FE_DATA_W-1:0] d;
        d = rand_data();
        d[8*12 +: 16] = 16'h0008;    // ethertype 0x0800 on the wire
        d[8*14 +: 8]  = 8'h45;
        d[8*15 +: 8]  = tos;
        d[8*16 +: 8]  = len[15:8];   // network order
        d[8*17 +: 8]  = len[7:0];
        d[8*23 +: 8]  = proto;
        return d;
    endfunction

    function automatic int code_width(input logic [1:0] code);
        case (code)
            2'd0:    return 0;
            2'd1:    return 8;
            2'd2:    return 16;
            default: return 32;
        endcase
    endfunction

    task automatic push_bits(input logic [31:0] value, input int n);
        for (int i = 0; i < n; i++) begin
            pay_bits.push_back(value[i]);
        end
    endtask

    task automatic build_bypass(input logic [7:0] proto, input logic [7:0] tos,
                                input logic [15:0] len, input int nbeats);
        axis_beat_t b;
        in_q.delete();
        model_q.delete();
        for (int i = 0; i < nbeats; i++) begin
            b.data = (i == 0) ? first_data(proto, tos, len) : rand_data();
            b.keep = (i == nbeats - 1) ? 32'h0000_ffff : '1;
            b.last = (i == nbeats - 1);
            in_q.push_back(b);
            model_q.push_back(b);   // bypass is unchanged
        end
        model_flag = 1'b0;   // ordinary packet
    endtask

    task automatic build_comp(input bit all_full, input int extra_beats);
        axis_beat_t            b;
        logic [15:0]           bitmap;
        logic [31:0]           val [`FE_LANES];
        logic [31:0]           mask;
        logic [7:0]            tos;
        int                    w;
        int                    nb;
        in_q.delete();
        model_q.delete();
        pay_bits.delete();
        tos = 8'($urandom % 255) + 8'd1;
        for (int i = 0; i < `FE_HDR_BEATS; i++) begin
            b.data = (i == 0) ? first_data(8'(`FE_IP_PROTO_TCP), tos,
                                           16'(`FE_COMP_FRAME_LEN - `FE_ETH_HDR_LEN))
                              : rand_data();
            b.keep = '1;
            b.last = 1'b0;
            in_q.push_back(b);
            model_q.push_back(b);
        end
        for (int g = 0; g < `FE_COMP_GROUPS; g++) begin
            for (int l = 0; l < `FE_LANES; l++) begin
                bitmap[2*l +: 2] = all_full ? 2'd3 : 2'($urandom);
                val[l]           = $urandom;
            end
            push_bits(32'(bitmap), `FE_BITMAP_W);
            b.data = '0;
            for (int l = 0; l < `FE_LANES; l++) begin
                w    = code_width(bitmap[2*l +: 2]);
                mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
                push_bits(val[l], w);
                b.data[32*l +: 32] = val[l] & mask;   // zero extended
            end
            b.keep = '1;
            b.last = (g == `FE_COMP_GROUPS - 1);
            model_q.push_back(b);
        end
        // junk after the last group, then whole junk beats
        while (pay_bits.size() % `FE_DATA_W != 0) begin
            pay_bits.push_back(1'($urandom));
        end
        nb = pay_bits.size() / `FE_DATA_W + extra_beats;
        for (int k = 0; k < nb; k++) begin
            b.data = rand_data();
            for (int i = 0; i < `FE_DATA_W; i++) begin
                if (k * `FE_DATA_W + i < pay_bits.size()) begin
                    b.data[i] = pay_bits[k * `FE_DATA_W + i];
                end
            end
            b.keep = '1;
            b.last = (k == nb - 1);
            in_q.push_back(b);
        end
        model_flag = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drive and check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic compare_beat(input axis_beat_t got, input axis_beat_t exp, input int idx);
        if (got !== exp) begin
            val_errs++;
            $display("FAIL t=%0t output beat %0d mismatch", $time, idx);
            $display("  got  data=%h keep=%h last=%b", got.data, got.keep, got.last);
            $display("  want data=%h keep=%h last=%b", exp.data, exp.keep, exp.last);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input int idx);
        if (got !== exp) begin
            val_errs++;
            $display("FAIL t=%0t need_decomp=%b at packet start beat %0d, expected %b",
                     $time, got, idx, exp);
        end
    endtask

    // caller sits 1 unit after a rising edge
    task automatic run_packet(input bit gaps);
        int idle;
        foreach (model_q[i]) begin
            exp_q.push_back(model_q[i]);
        end
        flag_q.push_back(model_flag);
        foreach (in_q[i]) begin
            idle = gaps ? int'($urandom % 3) : 0;
            if (idle != 0) begin
                s_valid = 1'b0;
                repeat (idle) @(posedge aclk);
                #1;
            end
            s_beat  = in_q[i];
            s_valid = 1'b1;
            @(posedge aclk);
            while (!s_ready) @(posedge aclk);
            #1;
        end
        s_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge aclk);
        repeat (20) @(posedge aclk);   // leftover beats must stay silent
        #1;
    endtask

    // output monitor
    always @(posedge aclk) begin
        if (aresetn && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("ERROR: output beat at time %0t when none was expected", $time);
            end else begin
                compare_beat(m_beat, exp_q.pop_front(), out_cnt);
            end
            if (pkt_start) begin
                if (flag_q.size() == 0) begin
                    other_errs++;
                    $display("ERROR: packet started at time %0t with no packet sent", $time);
                end else begin
                    compare_flag(need_decomp, flag_q.pop_front(), out_cnt);
                end
            end
            pkt_start = m_beat.last;
            out_cnt++;
        end
    end

    initial begin
        m_ready = 1'b1;
        forever begin
            @(posedge aclk);
            #1;
            m_ready = rand_ready ? 1'($urandom % 2) : 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic non_tcp_bypass();
        build_bypass(8'd17, 8'h10, 16'(`FE_COMP_FRAME_LEN - `FE_ETH_HDR_LEN), 6);
        run_packet(1'b0);
        wait_drain();
    endtask

    task automatic near_miss_bypass();
        build_bypass(8'(`FE_IP_PROTO_TCP), 8'h00,
                     16'(`FE_COMP_FRAME_LEN - `FE_ETH_HDR_LEN), 5);   // tos zero
        run_packet(1'b0);
        wait_drain();
    endtask

    task automatic all_full_decomp();
        build_comp(1'b1, 0);
        run_packet(1'b0);
        wait_drain();
    endtask

    task automatic random_code_decomp();
        build_comp(1'b0, 2);
        run_packet(1'b0);
        wait_drain();
    endtask

    // replays the last packet under back-pressure and input gaps
    task automatic stalled_replay();
        rand_ready = 1'b1;
        run_packet(1'b1);
        wait_drain();
        rand_ready = 1'b0;
    endtask

    task automatic back_to_back_order();
        build_bypass(8'd17, 8'h00, 16'd200, 3);
        run_packet(1'b0);
        build_comp(1'b0, 1);
        run_packet(1'b0);
        build_bypass(8'(`FE_IP_PROTO_TCP), 8'h20, 16'd986, 4);   // wrong length
        run_packet(1'b0);
        wait_drain();
    endtask

    initial begin
        int unsigned seed_ret;
        aresetn    = 1'b0;
        s_valid    = 1'b0;
        s_beat     = '0;
        rand_ready = 1'b0;
        val_errs   = 0;
        other_errs = 0;
        out_cnt    = 0;
        pkt_start  = 1'b1;
        seed_ret   = $urandom(32'heb74d10e);
        repeat (4) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        non_tcp_bypass();
        near_miss_bypass();
        all_full_decomp();
        random_code_decomp();
        stalled_replay();
        back_to_back_order();
        if (flag_q.size() != 0) begin
            other_errs++;
            $display("ERROR: %0d packets never appeared on the output", flag_q.size());
        end
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 val_errs, other_errs, frontend_top_inst.frontend_props_inst.assert_fails);
        if (val_errs == 0 && other_errs == 0 &&
            frontend_top_inst.frontend_props_inst.assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYC) @(posedge aclk);
        $display("ERROR: watchdog expired after %0d cycles, the DUT stopped moving data",
                 WATCHDOG_CYC);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/frontend_pkg.sv
src/pkt_classifier.sv
decomp/bit_window.sv
decomp/lane_unpack.sv
src/stream_out_merge.sv
src/frontend_top.sv
bench/clk_gen.sv
bench/frontend_props.sv
bench/tb_frontend.sv

// ==== Bender.yml ====
package:
  name: frontend

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/frontend_pkg.sv
      - src/pkt_classifier.sv
      - decomp/bit_window.sv
      - decomp/lane_unpack.sv
      - src/stream_out_merge.sv
      - src/frontend_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/clk_gen.sv
      - bench/frontend_props.sv
      - bench/tb_frontend.sv
